/* common/diagBusPkg.sv */
// Diagnostic bus command, decoded function entry and response types
// Shared by the command decoder, the command queue and the register block
`default_nettype none

package diagBusPkg;

  localparam int DIAG_SEL_W  = 3;
  localparam int DIAG_DATA_W = 6;

  // Command kind carried in the op field
  typedef enum logic [1:0] {NOP = 2'd0, CTL = 2'd1, LOAD = 2'd2, READ = 2'd3} diagOp_t;

  typedef logic [DIAG_SEL_W-1:0]  diagSel_t;
  typedef logic [DIAG_DATA_W-1:0] diagData_t;

  // Host command word, op in the top bits
  typedef struct packed {
    diagOp_t   op;
    diagSel_t  sel;
    diagData_t data;
  } diagCmd_t;

  // CTL function codes on sel, sel 0 and 4 are undefined
  localparam diagSel_t SEL_START       = 3'd1;
  localparam diagSel_t SEL_SINGLE_STEP = 3'd2;
  localparam diagSel_t SEL_STOP        = 3'd3;
  localparam diagSel_t SEL_BURST       = 3'd5;
  localparam diagSel_t SEL_SET_RESET   = 3'd6;
  localparam diagSel_t SEL_CLR_RESET   = 3'd7;

  // Highest defined read select
  localparam diagSel_t SEL_RD_MAX = 3'd3;

  typedef enum logic [2:0] {
    FN_NONE, FN_START, FN_SINGLE_STEP, FN_STOP, FN_BURST, FN_SET_RESET, FN_CLR_RESET
  } ctlFunc_t;

  // Load functions, encoded as the low digit of 042..045
  typedef enum logic [2:0] {
    LD_NONE = 3'd0, LD_BURST_LO = 3'd2, LD_BURST_HI = 3'd3,
    LD_RATE_SRC = 3'd4, LD_DOMAIN_DIS = 3'd5
  } ldFunc_t;

  // One queue entry, at most one of ctlFunc, ldFunc and readReq is active
  typedef struct packed {
    ctlFunc_t  ctlFunc;
    ldFunc_t   ldFunc;
    logic      readReq;
    diagSel_t  readSel;
    diagData_t data;
  } funcEntry_t;

endpackage

`default_nettype wire

/* common/clkCtlPkg.sv */
// Clock control types: run state, configuration and clock enable structs
// Also holds the fixed sizes of the command queue and the tick divider
`default_nettype none

package clkCtlPkg;

  localparam int QUEUE_DEPTH = 4;
  localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
  localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);
  localparam int DIV_WIDTH   = 3;

  typedef enum logic [1:0] {STOPPED, RUNNING, BURSTING, STEPPING} runState_t;

  typedef logic [1:0]             rateSel_t;
  typedef logic [1:0]             srcSel_t;
  typedef logic [7:0]             burstCnt_t;
  typedef logic [DIV_WIDTH-1:0]   divCnt_t;
  typedef logic [QUEUE_PTR_W-1:0] qPtr_t;
  typedef logic [QUEUE_CNT_W-1:0] qCnt_t;

  // Per-domain disables, set by a 045 load
  typedef struct packed {
    logic crm;
    logic edp;
    logic ctl;
  } domainDis_t;

  typedef struct packed {
    rateSel_t   rateSel;
    srcSel_t    srcSel;
    domainDis_t domainDis;
  } clkCfg_t;

  typedef struct packed {
    logic crm;
    logic edp;
    logic ctl;
  } domainClk_t;

endpackage

`default_nettype wire

/* rtl/diagCmdDecoder.sv */
// Checks host diagnostic commands and turns the defined ones into queue entries
// Undefined commands and NOPs are accepted and dropped
`timescale 1ns/1ps
`default_nettype none

module diagCmdDecoder (
  input  wire                    CLK,
  input  wire                    rst,
  input  diagBusPkg::diagCmd_t   cmd,
  input  wire                    cmdValid,
  output logic                   cmdReady,
  output diagBusPkg::funcEntry_t entry,
  output logic                   pushValid,
  input  wire                    pushReady
);

  diagBusPkg::funcEntry_t decEntry;
  logic                   decOk;
  logic                   cmdTake;
  logic                   pendValid;

  // A held entry leaves whenever the queue is ready, so both follow pushReady
  assign cmdReady  = pushReady;
  assign cmdTake   = cmdValid & cmdReady;
  assign pushValid = pendValid;

  always_comb begin
    decEntry = '0;
    decOk    = 1'b0;
    case (cmd.op)
      diagBusPkg::CTL: begin
        decOk = 1'b1;
        case (cmd.sel)
          diagBusPkg::SEL_START:       decEntry.ctlFunc = diagBusPkg::FN_START;
          diagBusPkg::SEL_SINGLE_STEP: decEntry.ctlFunc = diagBusPkg::FN_SINGLE_STEP;
          diagBusPkg::SEL_STOP:        decEntry.ctlFunc = diagBusPkg::FN_STOP;
          diagBusPkg::SEL_BURST:       decEntry.ctlFunc = diagBusPkg::FN_BURST;
          diagBusPkg::SEL_SET_RESET:   decEntry.ctlFunc = diagBusPkg::FN_SET_RESET;
          diagBusPkg::SEL_CLR_RESET:   decEntry.ctlFunc = diagBusPkg::FN_CLR_RESET;
          default:                     decOk = 1'b0;
        endcase
      end
      diagBusPkg::LOAD: begin
        // Load sel matches the ldFunc_t encoding, 042 to 045
        decOk         = 1'b1;
        decEntry.data = cmd.data;
        case (cmd.sel)
          3'd2:    decEntry.ldFunc = diagBusPkg::LD_BURST_LO;
          3'd3:    decEntry.ldFunc = diagBusPkg::LD_BURST_HI;
          3'd4:    decEntry.ldFunc = diagBusPkg::LD_RATE_SRC;
          3'd5:    decEntry.ldFunc = diagBusPkg::LD_DOMAIN_DIS;
          default: decOk = 1'b0;
        endcase
      end
      diagBusPkg::READ: begin
        decOk            = (cmd.sel <= diagBusPkg::SEL_RD_MAX);
        decEntry.readReq = decOk;
        decEntry.readSel = cmd.sel;
      end
      default: decOk = 1'b0;
    endcase
  end

  // One-entry output register
  always_ff @(posedge CLK) begin
    if (rst) begin
      pendValid <= 1'b0;
    end else if (cmdTake) begin
      pendValid <= decOk;
    end else if (pushReady) begin
      pendValid <= 1'b0;
    end
  end

  // Payload only loads for a defined command
  always_ff @(posedge CLK) begin
    if (cmdTake && decOk) begin
      entry <= decEntry;
    end
  end

endmodule

`default_nettype wire

/* rtl/cmdQueue.sv */
// Small circular FIFO of decoded function entries, valid/ready on both sides
// A full queue still takes a push in a cycle where its head is popped
`timescale 1ns/1ps
`default_nettype none

module cmdQueue (
  input  wire                    CLK,
  input  wire                    rst,
  input  diagBusPkg::funcEntry_t pushEntry,
  input  wire                    pushValid,
  output logic                   pushReady,
  output diagBusPkg::funcEntry_t head,
  output logic                   popValid,
  input  wire                    popReady
);

  diagBusPkg::funcEntry_t mem [clkCtlPkg::QUEUE_DEPTH];

  clkCtlPkg::qPtr_t wrPtr;
  clkCtlPkg::qPtr_t rdPtr;
  clkCtlPkg::qCnt_t count;
  logic             full;
  logic             live;
  logic             doPush;
  logic             doPop;

  assign full     = (count == clkCtlPkg::qCnt_t'(clkCtlPkg::QUEUE_DEPTH));
  assign popValid = (count != '0);
  assign head     = mem[rdPtr];

  // Held off until the first cycle out of reset
  assign pushReady = live & (~full | popReady);
  assign doPush    = pushValid & pushReady;
  assign doPop     = popValid & popReady;

  always_ff @(posedge CLK) begin
    if (rst) begin
      live  <= 1'b0;
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      live <= 1'b1;
      if (doPush) begin
        wrPtr <= wrPtr + clkCtlPkg::qPtr_t'(1);
      end
      if (doPop) begin
        rdPtr <= rdPtr + clkCtlPkg::qPtr_t'(1);
      end
      // Occupancy only moves when push and pop differ
      case ({doPush, doPop})
        2'b10:   count <= count + clkCtlPkg::qCnt_t'(1);
        2'b01:   count <= count - clkCtlPkg::qCnt_t'(1);
        default: count <= count;
      endcase
    end
  end

  // Entry storage
  always_ff @(posedge CLK) begin
    if (doPush) begin
      mem[wrPtr] <= pushEntry;
    end
  end

endmodule

`default_nettype wire

/* clkCtl/clkRunCtl.sv */
// Run controller: tick divider, run FSM, burst counter and clock enables
// Takes one CTL function per cycle from the register block
`timescale 1ns/1ps
`default_nettype none

module clkRunCtl (
  input  wire                     CLK,
  input  wire                     rst,
  input  diagBusPkg::ctlFunc_t    runFunc,
  input  clkCtlPkg::clkCfg_t      cfg,
  input  diagBusPkg::ldFunc_t     burstWr,
  input  diagBusPkg::diagData_t   burstData,
  output clkCtlPkg::runState_t    runState,
  output clkCtlPkg::burstCnt_t    burstCnt,
  output logic                    mrReset,
  output logic                    eboxClk,
  output clkCtlPkg::domainClk_t   domainClk
);

  clkCtlPkg::divCnt_t   divCnt;
  clkCtlPkg::runState_t stateNext;
  logic                 tick;
  logic                 burstZero;
  logic                 burstLast;
  logic                 clkActive;

  // Free-running divider
  always_ff @(posedge CLK) begin
    if (rst) begin
      divCnt <= '0;
    end else begin
      divCnt <= divCnt + clkCtlPkg::divCnt_t'(1);
    end
  end

  // Tick when the low rateSel bits are all zero
  always_comb begin
    case (cfg.rateSel)
      2'd0:    tick = 1'b1;
      2'd1:    tick = (divCnt[0] == 1'b0);
      2'd2:    tick = (divCnt[1:0] == 2'b00);
      default: tick = (divCnt == '0);
    endcase
  end

  assign burstZero = (burstCnt == '0);
  assign burstLast = (burstCnt == clkCtlPkg::burstCnt_t'(1));

  // A burst with nothing left gives no pulse
  always_comb begin
    case (runState)
      clkCtlPkg::RUNNING:  clkActive = 1'b1;
      clkCtlPkg::STEPPING: clkActive = 1'b1;
      clkCtlPkg::BURSTING: clkActive = ~burstZero;
      default:             clkActive = 1'b0;
    endcase
  end

  assign eboxClk       = tick & clkActive;
  assign domainClk.crm = eboxClk & ~cfg.domainDis.crm;
  assign domainClk.edp = eboxClk & ~cfg.domainDis.edp;
  assign domainClk.ctl = eboxClk & ~cfg.domainDis.ctl;

  always_comb begin
    stateNext = runState;
    // Step and burst end on their own
    case (runState)
      clkCtlPkg::STEPPING: begin
        if (eboxClk) stateNext = clkCtlPkg::STOPPED;
      end
      clkCtlPkg::BURSTING: begin
        if (burstZero || (eboxClk && burstLast)) stateNext = clkCtlPkg::STOPPED;
      end
      default: stateNext = runState;
    endcase
    // Host functions override
    case (runFunc)
      diagBusPkg::FN_START:       stateNext = clkCtlPkg::RUNNING;
      diagBusPkg::FN_SINGLE_STEP: stateNext = clkCtlPkg::STEPPING;
      diagBusPkg::FN_BURST:       stateNext = clkCtlPkg::BURSTING;
      diagBusPkg::FN_STOP:        stateNext = clkCtlPkg::STOPPED;
      default:                    stateNext = stateNext;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      runState <= clkCtlPkg::STOPPED;
      mrReset  <= 1'b1;
    end else begin
      runState <= stateNext;
      if (runFunc == diagBusPkg::FN_SET_RESET) begin
        mrReset <= 1'b1;
      end else if (runFunc == diagBusPkg::FN_CLR_RESET) begin
        mrReset <= 1'b0;
      end
    end
  end

  // Nibble loads win over the countdown
  always_ff @(posedge CLK) begin
    if (rst) begin
      burstCnt <= '0;
    end else if (burstWr == diagBusPkg::LD_BURST_LO) begin
      burstCnt[3:0] <= burstData[3:0];
    end else if (burstWr == diagBusPkg::LD_BURST_HI) begin
      burstCnt[7:4] <= burstData[3:0];
    end else if (eboxClk && runState == clkCtlPkg::BURSTING) begin
      // eboxClk in a burst implies a nonzero count
      burstCnt <= burstCnt - clkCtlPkg::burstCnt_t'(1);
    end
  end

endmodule

`default_nettype wire

/* clkCtl/clkDiagRegs.sv */
// Diagnostic register block: drains the queue, holds the clock configuration
// Forwards CTL and burst loads to the run controller and answers reads in order
`timescale 1ns/1ps
`default_nettype none

module clkDiagRegs (
  input  wire                     CLK,
  input  wire                     rst,
  input  diagBusPkg::funcEntry_t  head,
  input  wire                     popValid,
  output logic                    popReady,
  input  clkCtlPkg::runState_t    runState,
  input  clkCtlPkg::burstCnt_t    burstCnt,
  input  wire                     mrReset,
  output clkCtlPkg::clkCfg_t      cfg,
  output diagBusPkg::ctlFunc_t    runFunc,
  output diagBusPkg::ldFunc_t     burstWr,
  output diagBusPkg::diagData_t   burstData,
  output diagBusPkg::diagData_t   rsp,
  output logic                    rspValid,
  input  wire                     rspReady
);

  logic                  pop;
  logic                  rspStall;
  diagBusPkg::diagData_t rdWord;

  // A stalled response blocks everything behind it
  assign rspStall = rspValid & ~rspReady;
  assign popReady = ~rspStall;
  assign pop      = popValid & popReady;

  // CTL goes out in the pop cycle
  assign runFunc   = pop ? head.ctlFunc : diagBusPkg::FN_NONE;
  assign burstWr   = pop ? head.ldFunc : diagBusPkg::LD_NONE;
  assign burstData = head.data;

  // Read word layout, msb first
  always_comb begin
    case (head.readSel)
      3'd0:    rdWord = burstCnt[7:2];
      3'd1:    rdWord = {burstCnt[1:0], runState, mrReset, 1'b0};
      3'd2:    rdWord = {cfg.srcSel, cfg.rateSel, 2'b00};
      3'd3:    rdWord = {3'b000, cfg.domainDis.crm, cfg.domainDis.edp, cfg.domainDis.ctl};
      default: rdWord = '0;
    endcase
  end

  // Configuration loads, 044 and 045
  always_ff @(posedge CLK) begin
    if (rst) begin
      cfg <= '0;
    end else if (pop) begin
      if (head.ldFunc == diagBusPkg::LD_RATE_SRC) begin
        cfg.srcSel  <= head.data[3:2];
        cfg.rateSel <= head.data[1:0];
      end else if (head.ldFunc == diagBusPkg::LD_DOMAIN_DIS) begin
        cfg.domainDis <= head.data[2:0];
      end
    end
  end

  // Response handshake
  always_ff @(posedge CLK) begin
    if (rst) begin
      rspValid <= 1'b0;
    end else if (pop && head.readReq) begin
      rspValid <= 1'b1;
    end else if (rspReady) begin
      rspValid <= 1'b0;
    end
  end

  // Word only changes on a new read
  always_ff @(posedge CLK) begin
    if (pop && head.readReq) begin
      rsp <= rdWord;
    end
  end

endmodule

`default_nettype wire

/* clkCtl/clkCtl.sv */
// Clock control unit top, driven by the diagnostic command bus
// Decoder feeds the queue, the register block drains it and steers the run controller
`timescale 1ns/1ps
`default_nettype none

module clkCtl (
  input  wire                     CLK,
  input  wire                     rst,
  input  diagBusPkg::diagCmd_t    cmd,
  input  wire                     cmdValid,
  output logic                    cmdReady,
  output diagBusPkg::diagData_t   rsp,
  output logic                    rspValid,
  input  wire                     rspReady,
  output logic                    eboxClk,
  output clkCtlPkg::domainClk_t   domainClk,
  output logic                    mrReset
);

  diagBusPkg::funcEntry_t decEntry;
  logic                   pushValid;
  logic                   pushReady;
  diagBusPkg::funcEntry_t head;
  logic                   popValid;
  logic                   popReady;

  // Register block to run controller
  diagBusPkg::ctlFunc_t   runFunc;
  diagBusPkg::ldFunc_t    burstWr;
  diagBusPkg::diagData_t  burstData;
  clkCtlPkg::clkCfg_t     cfg;

  // Status back for readback
  clkCtlPkg::runState_t   runState;
  clkCtlPkg::burstCnt_t   burstCnt;

  diagCmdDecoder u_decoder (
    .CLK(CLK), .rst(rst),
    .cmd(cmd), .cmdValid(cmdValid), .cmdReady(cmdReady),
    .entry(decEntry), .pushValid(pushValid), .pushReady(pushReady)
  );

  cmdQueue u_queue (
    .CLK(CLK), .rst(rst),
    .pushEntry(decEntry), .pushValid(pushValid), .pushReady(pushReady),
    .head(head), .popValid(popValid), .popReady(popReady)
  );

  clkDiagRegs u_regs (
    .CLK(CLK), .rst(rst),
    .head(head), .popValid(popValid), .popReady(popReady),
    .runState(runState), .burstCnt(burstCnt), .mrReset(mrReset),
    .cfg(cfg), .runFunc(runFunc), .burstWr(burstWr), .burstData(burstData),
    .rsp(rsp), .rspValid(rspValid), .rspReady(rspReady)
  );

  clkRunCtl u_run (
    .CLK(CLK), .rst(rst),
    .runFunc(runFunc), .cfg(cfg), .burstWr(burstWr), .burstData(burstData),
    .runState(runState), .burstCnt(burstCnt), .mrReset(mrReset),
    .eboxClk(eboxClk), .domainClk(domainClk)
  );

endmodule

`default_nettype wire

/* verif/clkCtl_assert.sv */
// Concurrent checks on the run controller and register block signals
// Bound into the clock control top where both blocks meet
`timescale 1ns/1ps
`default_nettype none

module clkCtl_assert (
  input wire                   CLK,
  input wire                   rst,
  input diagBusPkg::diagData_t rsp,
  input wire                   rspValid,
  input wire                   rspReady,
  input wire                   eboxClk,
  input clkCtlPkg::rateSel_t   rateSel,
  input clkCtlPkg::burstCnt_t  burstCnt
);

  // Stalled response holds its word
  rspHold: assert property (@(posedge CLK) disable iff (rst)
    (rspValid && !rspReady) |=> (rspValid && $stable(rsp)))
    else $error("response changed while stalled");

  // Divided rates never pulse back to back
  tickGap: assert property (@(posedge CLK) disable iff (rst)
    (eboxClk && rateSel != 2'd0) |=> (!eboxClk || rateSel == 2'd0))
    else $error("clock enable high on consecutive cycles");

  // Countdown stops at zero
  noWrap: assert property (@(posedge CLK) disable iff (rst)
    (burstCnt == 8'h00) |=> (burstCnt != 8'hFF))
    else $error("burst count wrapped below zero");

endmodule

bind clkCtl clkCtl_assert u_assert (
  .CLK(CLK), .rst(rst),
  .rsp(rsp), .rspValid(rspValid), .rspReady(rspReady),
  .eboxClk(eboxClk), .rateSel(cfg.rateSel), .burstCnt(burstCnt)
);

`default_nettype wire

/* verif/clkCtl_tb.sv */
// Testbench for the clock control unit that drives diagnostic commands and checks reads
// Keeps a model of the registers and compares every response in order
`timescale 1ns/1ps
`default_nettype none

module clkCtl_tb;

  // Budget for bursts, rate runs and domain bursts plus slack for reads and back-pressure
  localparam int MAX_CYCLES = 6 * 600 + 4 * 400 + 4 * 500 + 4000;

  logic                  CLK = 1'b0;
  logic                  rst;
  diagBusPkg::diagCmd_t  cmd;
  logic                  cmdValid;
  logic                  cmdReady;
  diagBusPkg::diagData_t rsp;
  logic                  rspValid;
  logic                  rspReady = 1'b0;
  logic                  eboxClk;
  clkCtlPkg::domainClk_t domainClk;
  logic                  mrReset;

  // Register model updated on each accepted command
  logic [7:0] mCnt;
  logic [1:0] mState;
  logic       mReset;
  logic [1:0] mRate;
  logic [1:0] mSrc;
  logic [2:0] mDis;

  logic [5:0] expQ[$];
  logic [5:0] maskQ[$];
  logic [5:0] expWord;
  logic [5:0] expMask;
  logic [5:0] lastRsp;
  int         rspCount = 0;
  int         pulseCount = 0;
  int         crmCount = 0;
  int         edpCount = 0;
  int         ctlCount = 0;
  int         cycleNum = 0;
  int         lastPulse = 0;
  bit         havePrev = 0;
  bit         checkSpacing = 0;
  int         expSpacing = 1;
  string      testName = "reset";

  clkCtl u_dut (
    .CLK(CLK), .rst(rst),
    .cmd(cmd), .cmdValid(cmdValid), .cmdReady(cmdReady),
    .rsp(rsp), .rspValid(rspValid), .rspReady(rspReady),
    .eboxClk(eboxClk), .domainClk(domainClk), .mrReset(mrReset)
  );

  always #20 CLK = ~CLK;

  // Random host back-pressure on responses
  always @(posedge CLK) begin
    rspReady <= (($urandom % 4) != 0);
  end

  task automatic abortRun(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic mismatchStop(input int expVal, input int actVal);
    $display("Error %s: expected %0h, actual %0h", testName, expVal, actVal);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  // Expected read word with msb first
  function automatic logic [5:0] refWord(input logic [2:0] sel);
    case (sel)
      3'd0:    refWord = mCnt[7:2];
      3'd1:    refWord = {mCnt[1:0], mState, mReset, 1'b0};
      3'd2:    refWord = {mSrc, mRate, 2'b00};
      3'd3:    refWord = {3'b000, mDis};
      default: refWord = 6'h00;
    endcase
  endfunction

  // Drive one command and apply it to the model once it transfers
  task automatic issue(input logic [1:0] op, input logic [2:0] sel, input logic [5:0] data);
    @(posedge CLK);
    cmd      <= diagBusPkg::diagCmd_t'({op, sel, data});
    cmdValid <= 1'b1;
    @(negedge CLK);
    while (!cmdReady) @(negedge CLK);
    @(posedge CLK);
    cmdValid <= 1'b0;
    if (op == 2'd1) begin
      case (sel)
        3'd1: mState = 2'd1;
        3'd2: mState = 2'd3;
        3'd3: mState = 2'd0;
        3'd5: mState = 2'd2;
        3'd6: mReset = 1'b1;
        3'd7: mReset = 1'b0;
        default: ;
      endcase
    end else if (op == 2'd2) begin
      case (sel)
        3'd2: mCnt[3:0] = data[3:0];
        3'd3: mCnt[7:4] = data[3:0];
        3'd4: {mSrc, mRate} = data[3:0];
        3'd5: mDis = data[2:0];
        default: ;
      endcase
    end
  endtask

  task automatic readCheck(input logic [2:0] sel);
    expQ.push_back(refWord(sel));
    maskQ.push_back(6'h3F);
    issue(2'd3, sel, 6'h00);
  endtask

  // Poll read that checks only the known bits and returns the word to the caller
  task automatic readRaw(input logic [2:0] sel, input logic [5:0] mask,
                         output logic [5:0] word);
    int target;
    target = rspCount + expQ.size() + 1;
    expQ.push_back(refWord(sel));
    maskQ.push_back(mask);
    issue(2'd3, sel, 6'h00);
    while (rspCount < target) @(posedge CLK);
    word = lastRsp;
  endtask

  task automatic drain();
    while (expQ.size() != 0) @(posedge CLK);
  endtask

  // Poll status until the run FSM is back in STOPPED
  // Count and state move during a run, so only the reset bits are checked
  task automatic waitStopped();
    logic [5:0] w;
    readRaw(3'd1, 6'h03, w);
    while (w[3:2] != 2'd0) readRaw(3'd1, 6'h03, w);
    mState = 2'd0;
  endtask

  // Response compare and pulse counting on the falling edge
  always @(negedge CLK) begin
    if (!rst) begin
      cycleNum = cycleNum + 1;
      if (rspValid && rspReady) begin
        if (expQ.size() == 0) begin
          abortRun("Response arrived with no read outstanding");
        end else begin
          expWord = expQ.pop_front();
          expMask = maskQ.pop_front();
          assert ((rsp & expMask) == (expWord & expMask))
            else mismatchStop(expWord, rsp);
          lastRsp  = rsp;
          rspCount = rspCount + 1;
        end
      end
      // Domain enables only pulse together with eboxClk
      assert (eboxClk || domainClk == '0)
        else abortRun("Domain clock enable pulsed without eboxClk");
      if (eboxClk) begin
        pulseCount = pulseCount + 1;
        crmCount   = crmCount + domainClk.crm;
        edpCount   = edpCount + domainClk.edp;
        ctlCount   = ctlCount + domainClk.ctl;
        if (checkSpacing && havePrev) begin
          assert (cycleNum - lastPulse == expSpacing)
            else mismatchStop(expSpacing, cycleNum - lastPulse);
        end
        lastPulse = cycleNum;
        havePrev  = 1;
      end
    end
  end

  initial begin
    repeat (MAX_CYCLES) @(posedge CLK);
    abortRun("Timeout, the run did not finish in the expected number of cycles");
  end

  initial begin
    int          p0;
    int          c0;
    int          e0;
    int          t0;
    logic [7:0]  cnt;
    logic [5:0]  d;
    void'($urandom(32'h7cf3));
    rst      = 1'b1;
    cmd      = '0;
    cmdValid = 1'b0;
    {mCnt, mState, mReset, mRate, mSrc, mDis} = {8'h00, 2'd0, 1'b1, 2'd0, 2'd0, 3'd0};
    repeat (10) @(posedge CLK);
    rst <= 1'b0;

    // Machine reset flag
    @(negedge CLK);
    assert (!cmdReady && !rspValid && !eboxClk && domainClk == '0)
      else abortRun("Outputs not idle right after reset");
    assert (mrReset == 1'b1) else mismatchStop(1, mrReset);
    readCheck(3'd1);
    issue(2'd1, 3'd7, 6'h00);
    readCheck(3'd1);
    drain();
    assert (mrReset == 1'b0) else mismatchStop(0, mrReset);
    issue(2'd1, 3'd6, 6'h00);
    readCheck(3'd1);
    drain();
    assert (mrReset == 1'b1) else mismatchStop(1, mrReset);

    // Bursts of random length starting with an empty one
    testName = "burst";
    for (int i = 0; i < 6; i++) begin
      cnt = (i == 0) ? 8'h00 : 8'($urandom % 256);
      issue(2'd2, 3'd2, {2'b00, cnt[3:0]});
      issue(2'd2, 3'd3, {2'b00, cnt[7:4]});
      readCheck(3'd0);
      readCheck(3'd1);
      drain();
      p0 = pulseCount;
      issue(2'd1, 3'd5, 6'h00);
      waitStopped();
      mCnt = 8'h00;
      assert (pulseCount - p0 == int'(cnt)) else mismatchStop(cnt, pulseCount - p0);
      readCheck(3'd0);
      readCheck(3'd1);
      drain();
    end

    // Single step followed by a free run at every rate
    testName = "step";
    p0 = pulseCount;
    issue(2'd1, 3'd2, 6'h00);
    waitStopped();
    assert (pulseCount - p0 == 1) else mismatchStop(1, pulseCount - p0);
    testName = "rate";
    for (int r = 0; r < 4; r++) begin
      issue(2'd2, 3'd4, 6'(r));
      havePrev     = 0;
      expSpacing   = 1 << r;
      checkSpacing = 1;
      p0 = pulseCount;
      issue(2'd1, 3'd1, 6'h00);
      repeat (40) @(posedge CLK);
      issue(2'd1, 3'd3, 6'h00);
      waitStopped();
      checkSpacing = 0;
      assert (pulseCount - p0 > 2) else abortRun("Free run at a rate gave too few pulses");
    end

    // Configuration loads and domain enables
    testName = "config";
    for (int i = 0; i < 4; i++) begin
      issue(2'd2, 3'd4, 6'($urandom));
      issue(2'd2, 3'd5, 6'($urandom));
      readCheck(3'd2);
      readCheck(3'd3);
      drain();
      c0 = crmCount;
      e0 = edpCount;
      t0 = ctlCount;
      issue(2'd2, 3'd2, 6'h04);
      issue(2'd2, 3'd3, 6'h01);
      issue(2'd1, 3'd5, 6'h00);
      waitStopped();
      mCnt = 8'h00;
      assert (crmCount - c0 == (mDis[2] ? 0 : 20))
        else mismatchStop(mDis[2] ? 0 : 20, crmCount - c0);
      assert (edpCount - e0 == (mDis[1] ? 0 : 20))
        else mismatchStop(mDis[1] ? 0 : 20, edpCount - e0);
      assert (ctlCount - t0 == (mDis[0] ? 0 : 20))
        else mismatchStop(mDis[0] ? 0 : 20, ctlCount - t0);
    end

    // Read stream under back-pressure followed by undefined commands
    testName = "stream";
    for (int i = 0; i < 24; i++) begin
      readCheck(3'($urandom % 4));
    end
    drain();
    testName = "undefined";
    issue(2'd0, 3'd1, 6'h3F);
    issue(2'd1, 3'd0, 6'h00);
    issue(2'd1, 3'd4, 6'h00);
    for (int s = 0; s < 8; s++) begin
      if (s < 2 || s > 5) issue(2'd2, 3'(s), 6'h3F);
      if (s > 3) issue(2'd3, 3'(s), 6'h00);
    end
    // A dropped read that answers lands on an empty queue here
    repeat (20) @(posedge CLK);
    for (int s = 0; s < 4; s++) begin
      readCheck(3'(s));
    end
    drain();
    repeat (10) @(posedge CLK);

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
common/diagBusPkg.sv
common/clkCtlPkg.sv
rtl/diagCmdDecoder.sv
rtl/cmdQueue.sv
clkCtl/clkRunCtl.sv
clkCtl/clkDiagRegs.sv
clkCtl/clkCtl.sv
verif/clkCtl_assert.sv
verif/clkCtl_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the clock control testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  --top-module clkCtl_tb \
  -f tb.f \
  -o clkCtl_sim

./obj_dir/clkCtl_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "SIMULATION PASSED" sim.log; then
  exit 0
else
  exit 1
fi
